//--- logic/calc_num_pkg.sv
`default_nettype none

// Number-side definitions shared by entry, units and controller
package calc_num_pkg;

    localparam int word_w = 16;                 // Operand and result width
    localparam int radix  = 10;                 // Keypad entry base

    typedef logic [word_w-1:0] calc_word_t;     // Unsigned, wraps mod 2**word_w
    typedef logic [3:0]        digit_t;         // One keypad digit, 0..9

endpackage

`default_nettype wire

//--- logic/calc_op_pkg.sv
`default_nettype none

// Operation-side definitions: operator code, request, unit latencies
package calc_op_pkg;

    typedef enum logic [2:0] {
        op_add = 3'b001,                        // a + b
        op_sub = 3'b010,                        // a - b, wraps
        op_mul = 3'b100                         // low half of a * b
    } op_code_t;

    // One posted calculation, sampled by a unit on its start pulse
    typedef struct packed {
        op_code_t               op;             // Latched operator
        calc_num_pkg::calc_word_t a;            // First operand
        calc_num_pkg::calc_word_t b;            // Second operand
    } calc_req_t;

    localparam int add_sub_cycles = 4;          // One nibble per cycle
    localparam int mul_cycles     = 16;         // One multiplier bit per cycle

endpackage

`default_nettype wire

//--- logic/digit_entry.sv
`timescale 1ns/1ps
`default_nettype none

module digit_entry (
    input  logic                     clk,
    input  logic                     nRST,
    input  calc_num_pkg::digit_t     keypad_input,  // Digit on the keypad lines
    input  logic                     read_input,    // Take this digit
    input  logic                     clear,         // Start a new number
    output calc_num_pkg::calc_word_t value          // Running number
);

    calc_num_pkg::calc_word_t next_value;           // Value with the digit appended
    calc_num_pkg::calc_word_t digit_ext;            // Digit widened to a word

    assign digit_ext = calc_num_pkg::calc_word_t'(keypad_input);

    // x10 as x8 + x2, then add the digit; upper bits fall off
    always_comb begin
        next_value = (value << 3) + (value << 1) + digit_ext;
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            value <= '0;
        end else if (clear) begin                   // Clear wins over a digit
            value <= '0;
        end else if (read_input) begin
            value <= next_value;
        end
    end

    // Keypad only sends decimal digits
    digit_in_range: assert property (
        @(posedge clk) disable iff (!nRST)
        read_input |-> (int'(keypad_input) < calc_num_pkg::radix)
    ) else $error("digit_entry: keypad digit %0d out of range", keypad_input);

endmodule

`default_nettype wire

//--- logic/add_sub_unit.sv
`timescale 1ns/1ps
`default_nettype none

module add_sub_unit (
    input  logic                     clk,
    input  logic                     nRST,
    input  calc_op_pkg::calc_req_t   req,       // Sampled on start only
    input  logic                     start,
    output calc_num_pkg::calc_word_t result,    // Valid while finish is high
    output logic                     finish
);

    typedef logic [$clog2(calc_op_pkg::add_sub_cycles)-1:0] step_t;

    calc_num_pkg::calc_word_t a_sh;             // Operand a, low nibble next
    calc_num_pkg::calc_word_t b_sh;             // Operand b or ~b, low nibble next
    calc_num_pkg::calc_word_t sum;              // Result nibbles enter from the top
    logic                     carry;            // Carry between nibbles
    logic [4:0]               nib_sum;          // Nibble sum with carry out
    logic                     busy;
    step_t                    step;             // Nibble being added

    // Current nibble: a + b + carry
    assign nib_sum = {1'b0, a_sh[3:0]} + {1'b0, b_sh[3:0]} + {4'd0, carry};
    assign result  = sum;

    // Datapath, no reset
    always_ff @(posedge clk) begin
        if (start) begin
            a_sh  <= req.a;
            // Subtract as a + ~b + 1
            b_sh  <= (req.op == calc_op_pkg::op_sub) ? ~req.b : req.b;
            carry <= (req.op == calc_op_pkg::op_sub);
        end else if (busy) begin
            a_sh  <= a_sh >> 4;
            b_sh  <= b_sh >> 4;
            carry <= nib_sum[4];
            sum   <= {nib_sum[3:0], sum[calc_num_pkg::word_w-1:4]};
        end
    end

    // Step count and finish pulse
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            step   <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;                     // One-cycle pulse
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == step_t'(calc_op_pkg::add_sub_cycles - 1)) begin
                    busy   <= 1'b0;             // Last nibble lands with finish
                    finish <= 1'b1;
                end
            end
        end
    end

    // Controller waits for finish before posting again
    no_start_when_busy: assert property (
        @(posedge clk) disable iff (!nRST)
        start |-> !busy
    ) else $error("add_sub_unit: start while busy");

endmodule

`default_nettype wire

//--- logic/shift_add_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module shift_add_multiplier (
    input  logic                     clk,
    input  logic                     nRST,
    input  calc_op_pkg::calc_req_t   req,       // Sampled on start only
    input  logic                     start,
    output calc_num_pkg::calc_word_t result,    // Low half of the product
    output logic                     finish
);

    typedef logic [$clog2(calc_op_pkg::mul_cycles)-1:0] step_t;

    calc_num_pkg::calc_word_t mcand;            // Multiplicand, moves left
    calc_num_pkg::calc_word_t mplier;           // Multiplier, moves right
    calc_num_pkg::calc_word_t acc;              // Partial product, low bits only
    calc_num_pkg::calc_word_t acc_next;
    logic                     busy;
    step_t                    step;             // Multiplier bit in use

    // Add the shifted multiplicand when this bit is set
    always_comb begin
        acc_next = acc;
        if (mplier[0]) begin
            acc_next = acc + mcand;             // Carry past bit 15 is dropped
        end
    end

    assign result = acc;

    // Datapath, no reset
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= req.a;
            mplier <= req.b;
            acc    <= '0;
        end else if (busy) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;               // High bits never reach the low half
            mplier <= mplier >> 1;
        end
    end

    // Step count and finish pulse
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            step   <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;                     // One-cycle pulse
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == step_t'(calc_op_pkg::mul_cycles - 1)) begin
                    busy   <= 1'b0;             // Final add lands with finish
                    finish <= 1'b1;
                end
            end
        end
    end

    // Controller waits for finish before posting again
    no_start_when_busy: assert property (
        @(posedge clk) disable iff (!nRST)
        start |-> !busy
    ) else $error("shift_add_multiplier: start while busy");

endmodule

`default_nettype wire

//--- logic/calc_controller.sv
`timescale 1ns/1ps
`default_nettype none

module calc_controller (
    input  logic                     clk,
    input  logic                     nRST,
    input  logic [2:0]               operator_input,    // One-hot level from keypad
    input  logic                     equal_input,       // One-cycle strobe
    input  calc_num_pkg::calc_word_t value,             // Number being typed
    output logic                     clear,             // Zero the entry
    output calc_op_pkg::calc_req_t   req,               // Posted calculation
    output logic                     start_add,
    output logic                     start_mul,
    input  calc_num_pkg::calc_word_t add_result,
    input  logic                     add_finish,
    input  calc_num_pkg::calc_word_t mul_result,
    input  logic                     mul_finish,
    output logic                     complete,          // One-cycle done pulse
    output calc_num_pkg::calc_word_t display_output     // Held until next result
);

    typedef enum logic [2:0] {
        get_first,                      // Typing operand a
        get_second,                     // Typing operand b
        dispatch,                       // Start the chosen unit
        wait_unit,                      // Unit running
        show                            // complete is high
    } state_t;

    state_t state;
    state_t next_state;
    logic   op_valid;                   // Operator is one of the three codes
    logic   take_a;                     // Latch a and op this edge
    logic   take_b;                     // Latch b this edge
    logic   add_path;                   // Latched op goes to the adder

    assign op_valid = (operator_input == calc_op_pkg::op_add)
                   || (operator_input == calc_op_pkg::op_sub)
                   || (operator_input == calc_op_pkg::op_mul);
    assign take_a   = (state == get_first) && op_valid;
    assign take_b   = (state == get_second) && equal_input;
    assign add_path = (req.op == calc_op_pkg::op_add) || (req.op == calc_op_pkg::op_sub);

    // Zero entry on each capture, and drop keys while not collecting
    assign clear = take_a || take_b
                || (state == dispatch) || (state == wait_unit) || (state == show);

    // Latched op alone picks the unit
    assign start_add = (state == dispatch) && add_path;
    assign start_mul = (state == dispatch) && (req.op == calc_op_pkg::op_mul);

    always_comb begin
        next_state = state;
        case (state)
            get_first: begin
                if (op_valid) begin             // 000, 011, 111 etc. ignored
                    next_state = get_second;
                end
            end
            get_second: begin
                if (equal_input) begin
                    next_state = dispatch;
                end
            end
            dispatch:  next_state = wait_unit;
            wait_unit: begin
                if (add_finish || mul_finish) begin
                    next_state = show;
                end
            end
            show:      next_state = get_first;
            default:   next_state = get_first;
        endcase
    end

    // Request payload, no reset
    always_ff @(posedge clk) begin
        if (take_a) begin
            req.op <= calc_op_pkg::op_code_t'(operator_input);
            req.a  <= value;
        end
        if (take_b) begin
            req.b  <= value;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= get_first;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            state    <= next_state;
            complete <= 1'b0;
            if (state == wait_unit) begin
                if (add_finish) begin       // Result and complete on one edge
                    display_output <= add_result;
                    complete       <= 1'b1;
                end else if (mul_finish) begin
                    display_output <= mul_result;
                    complete       <= 1'b1;
                end
            end
        end
    end

    // Exactly one unit is started per calculation
    one_start: assert property (
        @(posedge clk) disable iff (!nRST)
        (state == dispatch) |-> (start_add ^ start_mul)
    ) else $error("calc_controller: both or neither unit started");

    // A unit only finishes work this controller is waiting on
    finish_in_wait: assert property (
        @(posedge clk) disable iff (!nRST)
        (add_finish || mul_finish) |-> (state == wait_unit)
    ) else $error("calc_controller: finish outside wait_unit");

endmodule

`default_nettype wire

//--- logic/calculator_top.sv
`timescale 1ns/1ps
`default_nettype none

module calculator_top (
    input  logic                     clk,
    input  logic                     nRST,
    input  calc_num_pkg::digit_t     keypad_input,
    input  logic                     read_input,
    input  logic [2:0]               operator_input,
    input  logic                     equal_input,
    output logic                     complete,
    output calc_num_pkg::calc_word_t display_output
);

    calc_num_pkg::calc_word_t value;            // Entry to controller
    logic                     clear;
    calc_op_pkg::calc_req_t   req;              // Shared by both units
    logic                     start_add;
    logic                     start_mul;
    calc_num_pkg::calc_word_t add_result;
    logic                     add_finish;
    calc_num_pkg::calc_word_t mul_result;
    logic                     mul_finish;

    digit_entry i_digit_entry (
        .clk          (clk),
        .nRST         (nRST),
        .keypad_input (keypad_input),
        .read_input   (read_input),
        .clear        (clear),
        .value        (value)
    );

    calc_controller i_calc_controller (
        .clk            (clk),
        .nRST           (nRST),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .value          (value),
        .clear          (clear),
        .req            (req),
        .start_add      (start_add),
        .start_mul      (start_mul),
        .add_result     (add_result),
        .add_finish     (add_finish),
        .mul_result     (mul_result),
        .mul_finish     (mul_finish),
        .complete       (complete),
        .display_output (display_output)
    );

    add_sub_unit i_add_sub_unit (
        .clk    (clk),
        .nRST   (nRST),
        .req    (req),
        .start  (start_add),
        .result (add_result),
        .finish (add_finish)
    );

    shift_add_multiplier i_shift_add_multiplier (
        .clk    (clk),
        .nRST   (nRST),
        .req    (req),
        .start  (start_mul),
        .result (mul_result),
        .finish (mul_finish)
    );

endmodule

`default_nettype wire

//--- sim/calculator_tb.sv
`timescale 1ns/1ps
`default_nettype none

module calculator_tb;

    localparam int reset_cycles   = 10;
    localparam int calc_cycles    = 60;     // Two 7-digit operands plus a multiply
    localparam int max_calcs      = 40;
    // Twice the longest run, plus reset and slack
    localparam int timeout_cycles = 2 * max_calcs * calc_cycles + 1200;

    logic                     clk = 1'b0;
    logic                     nRST;
    calc_num_pkg::digit_t     keypad_input;
    logic                     read_input;
    logic [2:0]               operator_input;
    logic                     equal_input;
    logic                     complete;
    calc_num_pkg::calc_word_t display_output;

    integer                   seed = 67;            // Operand digits
    int                       cycle_count = 0;
    int                       error_count = 0;
    int                       tests_run = 0;
    int                       tests_failed = 0;
    string                    test_name = "after_reset";
    calc_num_pkg::calc_word_t expected = '0;        // Result of the current test
    logic                     calc_started = 1'b0;  // First digit has been typed

    calculator_top i_calculator_top (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    always #2 clk = ~clk;                           // 4 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: complete never came within %0d cycles", timeout_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // Posted result against the model
    result_matches: assert property (
        @(posedge clk) disable iff (!nRST)
        complete |-> (display_output == expected)
    ) else begin
        $display("MISMATCH %s: expected %0d, actual %0d", test_name, expected, display_output);
        error_count = error_count + 1;
    end

    complete_one_cycle: assert property (
        @(posedge clk) disable iff (!nRST)
        complete |=> !complete
    ) else begin
        $display("complete stayed high for more than one cycle in %s", test_name);
        error_count = error_count + 1;
    end

    // Display only moves together with complete
    display_holds: assert property (
        @(posedge clk) disable iff (!nRST)
        (display_output != $past(display_output)) |-> complete
    ) else begin
        $display("display_output changed without a complete pulse in %s", test_name);
        error_count = error_count + 1;
    end

    quiet_after_reset: assert property (
        @(posedge clk) disable iff (!nRST)
        !calc_started |-> (!complete && (display_output == '0))
    ) else begin
        $display("complete or display_output active before the first calculation");
        error_count = error_count + 1;
    end

    // Decimal string of n random digits
    function automatic string random_digits(input int n);
        string s;
        int    d;
        s = "";
        for (int i = 0; i < n; i++) begin
            d = int'($unsigned($random(seed)) % 10);
            s = $sformatf("%s%0d", s, d);
        end
        return s;
    endfunction

    function automatic int random_len();
        return 1 + int'($unsigned($random(seed)) % 7);  // 1..7 digits, long ones wrap
    endfunction

    // Typed digits taken modulo 65536
    function automatic calc_num_pkg::calc_word_t entry_value(input string s);
        int unsigned acc;
        acc = 0;
        for (int i = 0; i < s.len(); i++) begin
            acc = (acc * 10 + (int'(s[i]) - 48)) % 65536;
        end
        return calc_num_pkg::calc_word_t'(acc);
    endfunction

    function automatic calc_num_pkg::calc_word_t expected_result(
        input logic [2:0] op,
        input calc_num_pkg::calc_word_t a,
        input calc_num_pkg::calc_word_t b
    );
        int unsigned r;
        case (op)
            calc_op_pkg::op_add: r = (32'(a) + 32'(b)) % 65536;
            calc_op_pkg::op_sub: r = (32'(a) + 65536 - 32'(b)) % 65536;   // Wraps below zero
            calc_op_pkg::op_mul: r = (32'(a) * 32'(b)) % 65536;           // Low half
            default:             r = 0;
        endcase
        return calc_num_pkg::calc_word_t'(r);
    endfunction

    // One read_input strobe per digit, idle cycle between
    task automatic type_digits(input string s);
        for (int i = 0; i < s.len(); i++) begin
            @(posedge clk);
            keypad_input <= 4'(s[i] - 8'd48);
            read_input   <= 1'b1;
            @(posedge clk);
            read_input   <= 1'b0;
        end
    endtask

    task automatic press_operator(input logic [2:0] code);
        @(posedge clk);
        operator_input <= code;                     // Held one cycle
        @(posedge clk);
        operator_input <= 3'b000;
    endtask

    task automatic press_equal();
        @(posedge clk);
        equal_input <= 1'b1;
        @(posedge clk);
        equal_input <= 1'b0;
    endtask

    // Sample at negedge, then let both complete assertions fire
    task automatic wait_complete();
        @(negedge clk);
        while (!complete) begin
            @(negedge clk);
        end
        @(posedge clk);
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic report_test(input int errors_before);
        tests_run = tests_run + 1;
        if (error_count != errors_before) begin
            tests_failed = tests_failed + 1;
            $display("test %s: FAIL", test_name);
        end else begin
            $display("test %s: ok, display %0d", test_name, display_output);
        end
    endtask

    task automatic check_idle();
        int errors_before;
        errors_before = error_count;
        test_name     = "after_reset";
        repeat (8) @(posedge clk);                  // Nothing typed, nothing posted
        @(negedge clk);
        report_test(errors_before);
    endtask

    task automatic run_calc(input string name, input string a_str, input logic [2:0] op,
                            input string b_str);
        int errors_before;
        errors_before = error_count;
        test_name     = name;
        expected      = expected_result(op, entry_value(a_str), entry_value(b_str));
        calc_started  = 1'b1;
        type_digits(a_str);
        press_operator(op);
        type_digits(b_str);
        press_equal();
        wait_complete();
        report_test(errors_before);
    endtask

    // Bad operator between two halves of operand a
    task automatic run_stray_calc(input string name, input string head, input logic [2:0] stray,
                                  input string tail, input logic [2:0] op, input string b_str);
        int errors_before;
        errors_before = error_count;
        test_name     = name;
        expected      = expected_result(op, entry_value({head, tail}), entry_value(b_str));
        calc_started  = 1'b1;
        type_digits(head);
        press_operator(stray);                      // Ignored by the controller
        type_digits(tail);
        press_operator(op);
        type_digits(b_str);
        press_equal();
        wait_complete();
        report_test(errors_before);
    endtask

    initial begin
        string a_str;
        string b_str;
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = 3'b000;
        equal_input    = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        nRST <= 1'b1;

        check_idle();

        run_calc("add_small", "123", calc_op_pkg::op_add, "456");
        run_calc("add_wrap", "99999", calc_op_pkg::op_add, "1");
        run_calc("add_long", "1234567", calc_op_pkg::op_add, "890123");
        for (int i = 0; i < 5; i++) begin
            a_str = random_digits(random_len());
            b_str = random_digits(random_len());
            run_calc($sformatf("add_rand_%0d", i), a_str, calc_op_pkg::op_add, b_str);
        end

        run_calc("sub_small", "500", calc_op_pkg::op_sub, "123");
        run_calc("sub_b_larger", "12", calc_op_pkg::op_sub, "345");
        run_calc("sub_zero_minus_one", "0", calc_op_pkg::op_sub, "1");
        for (int i = 0; i < 4; i++) begin
            a_str = random_digits(random_len());
            b_str = random_digits(random_len());
            run_calc($sformatf("sub_rand_%0d", i), a_str, calc_op_pkg::op_sub, b_str);
        end

        run_calc("mul_small", "123", calc_op_pkg::op_mul, "45");
        run_calc("mul_zero_a", "0", calc_op_pkg::op_mul, random_digits(4));
        run_calc("mul_zero_b", random_digits(5), calc_op_pkg::op_mul, "000");
        run_calc("mul_max", "65535", calc_op_pkg::op_mul, "65535");
        run_calc("mul_wrap", "300", calc_op_pkg::op_mul, "300");
        for (int i = 0; i < 4; i++) begin
            a_str = random_digits(random_len());
            b_str = random_digits(random_len());
            run_calc($sformatf("mul_rand_%0d", i), a_str, calc_op_pkg::op_mul, b_str);
        end

        run_stray_calc("stray_011", "12", 3'b011, "34", calc_op_pkg::op_add, "5");
        run_stray_calc("stray_000", "7", 3'b000, "08", calc_op_pkg::op_sub, "9");
        run_stray_calc("stray_111", "25", 3'b111, "6", calc_op_pkg::op_mul, "11");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
logic/calc_num_pkg.sv
logic/calc_op_pkg.sv
logic/digit_entry.sv
logic/add_sub_unit.sv
logic/shift_add_multiplier.sv
logic/calc_controller.sv
logic/calculator_top.sv
sim/calculator_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := calculator_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --assert -Wno-fatal -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)
PASS_MSG  := All checks passed

SOURCES   := $(shell cat $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Fails unless the pass message is printed
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
